/* dv/pcDemoTb.sv */
`timescale 1ns/1ps

module pcDemoTb;

  import boardPkg::*;
  import pcPkg::*;

  // load edge plus one shift per address bit
  localparam int convCycles = 33;

  logic          clk = 1'b0;
  logic          nRst;
  logic [15:0]   keys;
  logic          forceJump;
  logic          condJump;
  logic          condValue;
  logic          linkEnable;
  logic [31:0]   instructionAddress;
  logic [31:0]   linkAddress;
  logic [39:0]   segments;
  logic          displayValid;

  // model state owned by the stimulus
  logic [31:0]   modelAddr;
  logic [31:0]   expAddr;
  logic [31:0]   expLink;
  int            checkAt;
  // state owned by the comparing process
  int            cycleCount;
  logic [31:0]   curAddr;
  logic [31:0]   pendShow;
  logic [31:0]   shownAddr;
  logic [31:0]   expLinkNow;
  logic          expValid;
  // bookkeeping
  int            errors;
  int            checks;
  int            testStart;
  logic [31:0]   lcgState;
  logic [31:0]   rnd;

  pcDemoTop i_dut (
    .clk               (clk),
    .nRst              (nRst),
    .keys              (keys),
    .forceJump         (forceJump),
    .condJump          (condJump),
    .condValue         (condValue),
    .linkEnable        (linkEnable),
    .instructionAddress(instructionAddress),
    .linkAddress       (linkAddress),
    .segments          (segments),
    .displayValid      (displayValid)
  );

  // 8 ns period
  always #4 clk = ~clk;

  function automatic logic [31:0] nextRandom();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  // highest pressed key picks the offset, then the jump rule
  function automatic logic [31:0] nextAddress(input logic [31:0] addr,
      input logic [15:0] mask, input logic fj, input logic cj, input logic cv);
    int idx;
    int offset;
    idx = 0;
    for (int i = 0; i < numKeys; i++) begin
      if (mask[i]) begin
        idx = i;
      end
    end
    if (idx < 4) begin
      offset = (idx + 1) * 4;
    end else if (idx < 8) begin
      offset = -(idx - 3) * 4;
    end else begin
      offset = 0;
    end
    // 32-bit sum wraps like the hardware
    if (fj || (cj && cv)) begin
      return addr + offset;
    end
    return addr + 4;
  endfunction

  // low five decimal digits, digit 0 in the low byte
  function automatic logic [39:0] expectSegments(input logic [31:0] addr);
    logic [31:0] rest;
    logic [39:0] segs;
    rest = addr % 100000;
    for (int d = 0; d < defaultDigits; d++) begin
      segs[d*8 +: 8] = segPattern[rest % 10];
      rest = rest / 10;
    end
    return segs;
  endfunction

  task automatic finishRun();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  endtask

  task automatic reportTest(input string name);
    $display("%s: %0d errors", name, errors - testStart);
    testStart = errors;
  endtask

  task automatic waitValid();
    int count;
    count = 0;
    while (!displayValid && count < 200) begin
      @(posedge clk);
      count++;
    end
    if (!displayValid) begin
      $display("timeout: displayValid stayed low for 200 cycles");
      errors++;
      finishRun();
    end
  endtask

  // sw holds forceJump, condJump, condValue, linkEnable from msb down
  task automatic pressKey(input logic [15:0] mask, input logic [3:0] sw,
      input int holdCycles);
    @(posedge clk);
    keys       <= mask;
    forceJump  <= sw[3];
    condJump   <= sw[2];
    condValue  <= sw[1];
    linkEnable <= sw[0];
    expLink    = sw[0] ? modelAddr + 32'd4 : 32'h0;
    modelAddr  = nextAddress(modelAddr, mask, sw[3], sw[2], sw[1]);
    expAddr    = modelAddr;
    // synchronizer plus counter register
    checkAt    = cycleCount + 2;
    repeat (holdCycles) @(posedge clk);
    keys <= '0;
    repeat (3) @(posedge clk);
    waitValid();
  endtask

  // sampled on the falling edge, away from the driving edge
  always @(negedge clk) begin
    if (cycleCount == checkAt) begin
      curAddr  = expAddr;
      pendShow = expAddr;
    end
    expLinkNow = (cycleCount == checkAt) ? expLink : 32'h0;
    // dark from the cycle after stepped until the last shift is done
    expValid = !(cycleCount > checkAt && cycleCount <= checkAt + convCycles);
    checks = checks + 4;
    assert (instructionAddress == curAddr) else begin
      $display("FAIL instructionAddress got %h expected %h", instructionAddress, curAddr);
      errors++;
    end
    assert (linkAddress == expLinkNow) else begin
      $display("FAIL linkAddress got %h expected %h", linkAddress, expLinkNow);
      errors++;
    end
    assert (displayValid == expValid) else begin
      $display("FAIL displayValid got %h expected %h", displayValid, expValid);
      errors++;
    end
    if (!expValid) begin
      // conversion running, digits dark
      shownAddr = pendShow;
      assert (segments == 40'h0) else begin
        $display("FAIL segments got %h expected %h", segments, 40'h0);
        errors++;
      end
    end else begin
      assert (segments == expectSegments(shownAddr)) else begin
        $display("FAIL segments got %h expected %h", segments, expectSegments(shownAddr));
        errors++;
      end
    end
    cycleCount <= cycleCount + 1;
  end

  initial begin
    nRst = 1'b0;
    keys = '0;
    forceJump = 1'b0;
    condJump = 1'b0;
    condValue = 1'b0;
    linkEnable = 1'b0;
    modelAddr = resetAddress;
    expAddr = resetAddress;
    expLink = '0;
    // no step predicted yet
    checkAt = -100;
    cycleCount = 0;
    curAddr = resetAddress;
    pendShow = resetAddress;
    shownAddr = resetAddress;
    errors = 0;
    checks = 0;
    testStart = 0;
    lcgState = 32'h1981fc11;
    repeat (8) @(posedge clk);
    nRst <= 1'b1;
    repeat (2) @(posedge clk);

    // sequential steps, switches low
    pressKey(16'h0001, 4'b0000, 3);
    pressKey(16'h0020, 4'b0000, 3);
    pressKey(16'h8000, 4'b0000, 3);
    reportTest("test 1 reset and sequential steps");

    // every key forced, then a wrap below zero
    for (int k = 0; k < numKeys; k++) begin
      pressKey(16'h0001 << k, 4'b1000, 3);
    end
    pressKey(16'h0080, 4'b1000, 3);
    reportTest("test 2 forced jumps");

    pressKey(16'h0002, 4'b0100, 3);
    pressKey(16'h0002, 4'b0110, 3);
    pressKey(16'h0004, 4'b0010, 3);
    pressKey(16'h0010, 4'b0110, 3);
    reportTest("test 3 conditional jumps");

    pressKey(16'h0001, 4'b0001, 3);
    pressKey(16'h0008, 4'b1001, 3);
    pressKey(16'h0001, 4'b0000, 3);
    reportTest("test 4 link address");

    // long hold still gives one step
    pressKey(16'h0001, 4'b0000, 12);
    pressKey(16'h000a, 4'b1000, 3);
    pressKey(16'h0041, 4'b1000, 3);
    pressKey(16'h0104, 4'b1000, 3);
    reportTest("test 5 held and multiple keys");

    // backward jumps until the address is past five digits
    while (modelAddr < 100000) begin
      pressKey(16'h0080, 4'b1000, 3);
    end
    repeat (20) begin
      rnd = nextRandom();
      pressKey(16'h0001 << rnd[31:28], rnd[27:24], 3);
    end
    reportTest("test 6 random steps and display");

    repeat (2) @(posedge clk);
    finishRun();
  end

endmodule

/* logic/bcdConverter.sv */
`timescale 1ns/1ps

module bcdConverter #(
  parameter int addrWidth = pcPkg::addrWidth,
  parameter int numDigits = boardPkg::defaultDigits
) (
  input  logic                   clk,
  input  logic                   nRst,
  input  logic                   start,
  input  logic [addrWidth-1:0]   binary,
  output logic [numDigits*4-1:0] digits,
  output logic                   valid
);

  localparam int bcdWidth   = numDigits * 4;
  localparam int countWidth = $clog2(addrWidth + 1);

  // conversion in progress
  logic                  busy;
  // shifts still to do
  logic [countWidth-1:0] bitCount;
  // binary bits not yet shifted in, msb first
  logic [addrWidth-1:0]  binShift;
  // running BCD value
  logic [bcdWidth-1:0]   bcdShift;
  // BCD value after the add-3 step
  logic [bcdWidth-1:0]   bcdAdjusted;

  // add 3 to every digit of 5 or more before doubling
  always_comb begin
    bcdAdjusted = bcdShift;
    for (int d = 0; d < numDigits; d++) begin
      if (bcdShift[d*4 +: 4] >= 4'd5) begin
        bcdAdjusted[d*4 +: 4] = bcdShift[d*4 +: 4] + 4'd3;
      end
    end
  end

  // control and result registers
  always_ff @(posedge clk or negedge nRst) begin
    if (!nRst) begin
      busy     <= 1'b0;
      bitCount <= '0;
      digits   <= '0;
      // idle with zeros shown
      valid    <= 1'b1;
    end else if (start) begin
      // restart even in the middle of a conversion
      busy     <= 1'b1;
      bitCount <= countWidth'(addrWidth);
      valid    <= 1'b0;
    end else if (busy) begin
      if (bitCount != '0) begin
        bitCount <= bitCount - 1'b1;
      end else begin
        // all bits in, publish the digits
        busy   <= 1'b0;
        digits <= bcdShift;
        valid  <= 1'b1;
      end
    end
  end

  // datapath shift registers
  always_ff @(posedge clk) begin
    if (start) begin
      binShift <= binary;
      bcdShift <= '0;
    end else if (busy && bitCount != '0) begin
      // carry out of the top digit is lost, so the result is mod 10^numDigits
      bcdShift <= {bcdAdjusted[bcdWidth-2:0], binShift[addrWidth-1]};
      binShift <= {binShift[addrWidth-2:0], 1'b0};
    end
  end

  // decimal digits only once the result is shown
  for (genvar d = 0; d < numDigits; d++) begin : gDigitCheck
    digitDecimal: assert property (@(posedge clk) disable iff (!nRst)
      valid |-> (digits[d*4 +: 4] <= 4'd9));
  end

endmodule

/* logic/boardPkg.sv */
package boardPkg;

  // lab board I/O description

  // keypad
  // one level per key, asynchronous to clk
  localparam int numKeys = 16;

  // width of an encoded key index
  localparam int keyIndexWidth = $clog2(numKeys);

  // seven-segment display
  // number of decimal digits shown by default
  localparam int defaultDigits = 5;

  // segment bytes, bit 0 is segment a, bit 6 is segment g
  // bit 7 (decimal point) stays off in every entry
  // entries 10 to 15 hold hex letters A to F
  localparam logic [7:0] segPattern [16] = '{
    8'h3f, 8'h06, 8'h5b, 8'h4f,
    8'h66, 8'h6d, 8'h7d, 8'h07,
    8'h7f, 8'h67, 8'h77, 8'h7c,
    8'h39, 8'h5e, 8'h79, 8'h71
  };

  // an all-dark digit
  localparam logic [7:0] segBlank = 8'h00;

endpackage

/* logic/keyCommand.sv */
`timescale 1ns/1ps

module keyCommand #(
  parameter int addrWidth = pcPkg::addrWidth
) (
  input  logic                          clk,
  input  logic                          nRst,
  input  logic [boardPkg::numKeys-1:0]  keys,
  output logic                          step,
  output logic [addrWidth-1:0]          jumpOffset
);

  import boardPkg::*;
  import pcPkg::*;

  // highest pressed key, straight from the pad
  logic [keyIndexWidth-1:0] highestKey;
  // stage one of the synchronizer plus the index captured with it
  logic                     keyAny1;
  logic [keyIndexWidth-1:0] keyIndex1;
  // stage two, previous value of stage one
  logic                     keyAny2;
  // signed jump distance in words
  int                       offsetWords;

  // priority encoder, last hit wins so the highest index is kept
  always_comb begin
    highestKey = '0;
    for (int i = 0; i < numKeys; i++) begin
      if (keys[i]) begin
        highestKey = keyIndexWidth'(i);
      end
    end
  end

  // two-flop synchronizer on the OR of all keys
  always_ff @(posedge clk or negedge nRst) begin
    if (!nRst) begin
      keyAny1 <= 1'b0;
      keyAny2 <= 1'b0;
    end else begin
      keyAny1 <= |keys;
      keyAny2 <= keyAny1;
    end
  end

  // index sampled on the same edge as stage one
  always_ff @(posedge clk) begin
    keyIndex1 <= highestKey;
  end

  // rising edge of stage one
  assign step = keyAny1 & ~keyAny2;

  // keys 0-3 jump forward 1..4 words
  // keys 4-7 jump backward 1..4 words
  // upper keys give no offset
  always_comb begin
    if (keyIndex1 <= keyIndexWidth'(3)) begin
      offsetWords = int'(keyIndex1) + 1;
    end else if (keyIndex1 <= keyIndexWidth'(7)) begin
      offsetWords = 3 - int'(keyIndex1);
    end else begin
      offsetWords = 0;
    end
  end

  // signed product, sign extended to the address width
  assign jumpOffset = addrWidth'(offsetWords * stepBytes);

  // key must drop for a cycle before another step
  stepOnePulse: assert property (@(posedge clk) disable iff (!nRst)
    step |=> !step);

  // offsets keep the counter word aligned
  offsetAligned: assert property (@(posedge clk) disable iff (!nRst)
    step |-> (jumpOffset[1:0] == 2'b00));

endmodule

/* logic/pcDemoTop.sv */
`timescale 1ns/1ps

module pcDemoTop #(
  parameter int addrWidth = pcPkg::addrWidth,
  parameter int numDigits = boardPkg::defaultDigits
) (
  input  logic                          clk,
  input  logic                          nRst,
  input  logic [boardPkg::numKeys-1:0]  keys,
  input  logic                          forceJump,
  input  logic                          condJump,
  input  logic                          condValue,
  input  logic                          linkEnable,
  output logic [addrWidth-1:0]          instructionAddress,
  output logic [addrWidth-1:0]          linkAddress,
  output logic [numDigits*8-1:0]        segments,
  output logic                          displayValid
);

  // key press strobe and its mapped offset
  logic                   step;
  logic [addrWidth-1:0]   jumpOffset;
  // counter update pulse, starts the conversion
  logic                   stepped;
  // decimal digits, digit 0 least significant
  logic [numDigits*4-1:0] digits;

  // input side
  keyCommand #(
    .addrWidth(addrWidth)
  ) i_keyCommand (
    .clk       (clk),
    .nRst      (nRst),
    .keys      (keys),
    .step      (step),
    .jumpOffset(jumpOffset)
  );

  // processing
  programCounter #(
    .addrWidth(addrWidth)
  ) i_programCounter (
    .clk               (clk),
    .nRst              (nRst),
    .step              (step),
    .jumpOffset        (jumpOffset),
    .forceJump         (forceJump),
    .condJump          (condJump),
    .condValue         (condValue),
    .linkEnable        (linkEnable),
    .instructionAddress(instructionAddress),
    .linkAddress       (linkAddress),
    .stepped           (stepped)
  );

  // output side
  bcdConverter #(
    .addrWidth(addrWidth),
    .numDigits(numDigits)
  ) i_bcdConverter (
    .clk   (clk),
    .nRst  (nRst),
    .start (stepped),
    .binary(instructionAddress),
    .digits(digits),
    .valid (displayValid)
  );

  // one decoder per digit
  // display dark while a conversion runs
  for (genvar d = 0; d < numDigits; d++) begin : gSeg
    segDecode i_segDecode (
      .digit   (digits[d*4 +: 4]),
      .blank   (!displayValid),
      .segments(segments[d*8 +: 8])
    );
  end

endmodule

/* logic/pcPkg.sv */
package pcPkg;

  // instruction address datapath

  // default address width
  // top level takes this as its parameter default
  localparam int addrWidth = 32;

  // sequential advance in bytes, one 32-bit instruction word
  // jump offsets are scaled by the same word size
  localparam int stepBytes = 4;

  // address loaded while nRst is low
  // must stay word aligned
  localparam int resetAddress = 0;

endpackage

/* logic/programCounter.sv */
`timescale 1ns/1ps

module programCounter #(
  parameter int addrWidth = pcPkg::addrWidth
) (
  input  logic                 clk,
  input  logic                 nRst,
  input  logic                 step,
  input  logic [addrWidth-1:0] jumpOffset,
  input  logic                 forceJump,
  input  logic                 condJump,
  input  logic                 condValue,
  input  logic                 linkEnable,
  output logic [addrWidth-1:0] instructionAddress,
  output logic [addrWidth-1:0] linkAddress,
  output logic                 stepped
);

  import pcPkg::*;

  // jump rule from the switch levels
  logic                 takeJump;
  // fall-through address, also the return address
  logic [addrWidth-1:0] seqAddress;
  // relative jump target
  logic [addrWidth-1:0] jumpAddress;

  assign takeJump    = forceJump | (condJump & condValue);
  assign seqAddress  = instructionAddress + addrWidth'(stepBytes);
  // wraps modulo 2^addrWidth on a backward jump below 0
  assign jumpAddress = instructionAddress + jumpOffset;

  always_ff @(posedge clk or negedge nRst) begin
    if (!nRst) begin
      instructionAddress <= addrWidth'(resetAddress);
      linkAddress        <= '0;
      stepped            <= 1'b0;
    end else begin
      // done pulse lines up with the new address
      stepped <= step;
      if (step) begin
        if (takeJump) begin
          instructionAddress <= jumpAddress;
        end else begin
          instructionAddress <= seqAddress;
        end
        // return address only when asked for
        if (linkEnable) begin
          linkAddress <= seqAddress;
        end else begin
          linkAddress <= '0;
        end
      end else begin
        // link is a one-step pulse
        linkAddress <= '0;
      end
    end
  end

  // relies on the offset map upstream
  addrAligned: assert property (@(posedge clk) disable iff (!nRst)
    instructionAddress[1:0] == 2'b00);

  // address only moves on a step
  addrHolds: assert property (@(posedge clk) disable iff (!nRst)
    !step |=> $stable(instructionAddress));

endmodule

/* logic/segDecode.sv */
`timescale 1ns/1ps

module segDecode (
  input  logic [3:0] digit,
  input  logic       blank,
  output logic [7:0] segments
);

  import boardPkg::*;

  // purely combinational lookup
  // blank and non-decimal codes both give a dark digit
  always_comb begin
    if (blank) begin
      segments = segBlank;
    end else if (digit > 4'd9) begin
      // hex letters are never shown here
      segments = segBlank;
    end else begin
      segments = segPattern[digit];
    end
  end

endmodule

/* pcDemo.f */
logic/boardPkg.sv
logic/pcPkg.sv
logic/keyCommand.sv
logic/programCounter.sv
logic/bcdConverter.sv
logic/segDecode.sv
logic/pcDemoTop.sv
dv/pcDemoTb.sv
